// ==== src.f ====
src/periph_pkg.sv
src/periph_decode.sv
src/gpio_ctrl.sv
src/scratch_periph.sv
src/byte_regs_periph.sv
src/read_hold.sv
src/pin_mux.sv
src/periph_top.sv
tb/tb_clock.sv
tb/periph_top_tb.sv

// ==== src/byte_regs_periph.sv ====
`default_nettype none
`timescale 1ns/10ps

module byte_regs_periph #(
    parameter int NUM_REGS = 4   // 1 to 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_write,
    input  logic [3:0]        i_offset,
    input  periph_pkg::byte_t i_data,
    output periph_pkg::byte_t o_rdata,
    output periph_pkg::byte_t o_pins
);

    periph_pkg::byte_t regs [NUM_REGS];

    // Offsets past the file drop the write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (i_write) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                if (i_offset == 4'(r)) begin
                    regs[r] <= i_data;
                end
            end
        end
    end

    always_comb begin
        o_rdata = '0;  // Unbacked offsets read zero
        for (int r = 0; r < NUM_REGS; r++) begin
            if (i_offset == 4'(r)) begin
                o_rdata = regs[r];
            end
        end
    end

    assign o_pins = regs[0];

endmodule

`default_nettype wire

// ==== src/gpio_ctrl.sv ====
`default_nettype none
`timescale 1ns/10ps

module gpio_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_sel,
    input  logic                  i_write,
    input  logic [5:0]            i_offset,
    input  periph_pkg::data_t     i_data,
    input  periph_pkg::byte_t     i_pins_in,
    output periph_pkg::byte_t     o_gpio_out,
    output periph_pkg::func_sel_t o_func_sel [8],
    output periph_pkg::data_t     o_rdata
);

    logic       wr_en;
    logic       sel_hit;
    logic [2:0] sel_idx;

    assign wr_en = i_sel && i_write;

    // Select registers sit on a word stride from the base
    assign sel_hit = (i_offset >= periph_pkg::GPIO_SEL_BASE) && (i_offset[1:0] == 2'b00);
    assign sel_idx = i_offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_gpio_out <= '0;
        end else if (wr_en && i_offset == periph_pkg::GPIO_OUT_OFS) begin
            o_gpio_out <= i_data[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int n = 0; n < 8; n++) begin
                o_func_sel[n] <= {1'b0, periph_pkg::SLOT_GPIO}; // Every pin on GPIO
            end
        end else if (wr_en && sel_hit) begin
            o_func_sel[sel_idx] <= i_data[4:0];
        end
    end

    // Readback
    always_comb begin
        if (i_offset == periph_pkg::GPIO_OUT_OFS) begin
            o_rdata = {24'h0, o_gpio_out};
        end else if (i_offset == periph_pkg::GPIO_IN_OFS) begin
            o_rdata = {24'h0, i_pins_in};
        end else if (sel_hit) begin
            o_rdata = {27'h0, o_func_sel[sel_idx]};
        end else begin
            o_rdata = '0;
        end
    end

endmodule

`default_nettype wire

// ==== src/periph_decode.sv ====
`default_nettype none
`timescale 1ns/10ps

module periph_decode (
    input  periph_pkg::addr_t   i_addr,
    input  periph_pkg::size_n_t i_read_n,
    input  logic                i_hold_ready,
    input  periph_pkg::data_t   i_user_data [16],
    input  logic [15:0]         i_user_ready,
    input  periph_pkg::byte_t   i_simple_data [16],
    output logic [15:0]         o_user_sel,
    output logic [15:0]         o_simple_sel,
    output logic                o_read_start,
    output periph_pkg::data_t   o_peri_data,
    output logic                o_peri_ready
);

    periph_pkg::slot_t user_slot;
    periph_pkg::slot_t simple_slot;
    logic              simple_grp;

    assign simple_grp  = i_addr[10];
    assign user_slot   = i_addr[9:6];  // 64 byte windows
    assign simple_slot = i_addr[7:4];  // 16 byte windows

    // Held result masks the read so it is not issued twice
    assign o_read_start = (i_read_n != periph_pkg::SIZE_IDLE) && !i_hold_ready;

    always_comb begin
        o_user_sel   = '0;
        o_simple_sel = '0;

        if (simple_grp) begin
            o_simple_sel[simple_slot] = 1'b1;
            o_peri_data  = {24'h0, i_simple_data[simple_slot]};
            o_peri_ready = 1'b1;   // Byte slots answer at once
        end else begin
            o_user_sel[user_slot] = 1'b1;
            o_peri_data  = i_user_data[user_slot];
            o_peri_ready = i_user_ready[user_slot];
        end
    end

endmodule

`default_nettype wire

// ==== src/periph_pkg.sv ====
`default_nettype none

package periph_pkg;

    // Bus and pin widths
    typedef logic [10:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [7:0]  byte_t;
    typedef logic [1:0]  size_n_t;   // Active low size code
    typedef logic [4:0]  func_sel_t; // Bit 4 picks the simple group
    typedef logic [3:0]  slot_t;

    // Slot numbers
    localparam slot_t SLOT_GPIO      = 4'd1;  // User group
    localparam slot_t SLOT_SCRATCH   = 4'd3;  // User group
    localparam slot_t SLOT_BYTE_REGS = 4'd0;  // Simple group

    // Size codes
    localparam size_n_t SIZE_BYTE = 2'd0;
    localparam size_n_t SIZE_HALF = 2'd1;
    localparam size_n_t SIZE_WORD = 2'd2;
    localparam size_n_t SIZE_IDLE = 2'd3;

    // GPIO register offsets
    localparam logic [5:0] GPIO_OUT_OFS  = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS   = 6'h04;
    localparam logic [5:0] GPIO_SEL_BASE = 6'h20; // Pin n at base + 4n

    // Scratch register offsets
    localparam logic [5:0] SCRATCH_DATA_OFS = 6'h00;
    localparam logic [5:0] SCRATCH_IRQ_OFS  = 6'h04;

endpackage

`default_nettype wire

// ==== src/periph_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module periph_top (
    input  logic                clk,
    input  logic                rst_n,
    input  periph_pkg::byte_t   i_pins_in,
    output periph_pkg::byte_t   o_pins,
    input  periph_pkg::addr_t   i_addr,
    input  periph_pkg::data_t   i_data,
    input  periph_pkg::size_n_t i_write_n,
    input  periph_pkg::size_n_t i_read_n,
    input  logic                i_read_complete,
    output periph_pkg::data_t   o_data,
    output logic                o_data_ready,
    output logic                o_user_interrupt
);

    localparam int NUM_BYTE_REGS = 4;

    wire periph_pkg::data_t     user_data [16];
    wire [15:0]                 user_ready;
    wire periph_pkg::byte_t     user_pins [16];
    wire periph_pkg::byte_t     simple_data [16];
    wire periph_pkg::byte_t     simple_pins [16];
    wire periph_pkg::func_sel_t func_sel [8];
    wire [15:0]                 user_sel;
    wire [15:0]                 simple_sel;
    wire periph_pkg::data_t     peri_data;
    wire                        peri_ready;
    wire                        read_start;
    wire                        hold_ready;
    wire                        write_req;
    wire                        read_req;
    wire                        byte_write;

    assign write_req  = i_write_n != periph_pkg::SIZE_IDLE;
    assign read_req   = i_read_n != periph_pkg::SIZE_IDLE;
    assign byte_write = write_req && simple_sel[periph_pkg::SLOT_BYTE_REGS];

    // Empty slots read zero and answer at once
    for (genvar s = 0; s < 16; s++) begin : g_tie
        if (s != periph_pkg::SLOT_GPIO && s != periph_pkg::SLOT_SCRATCH) begin : g_user
            assign user_data[s]  = '0;
            assign user_ready[s] = 1'b1;
            assign user_pins[s]  = '0;
        end
        if (s != periph_pkg::SLOT_BYTE_REGS) begin : g_simple
            assign simple_data[s] = '0;
            assign simple_pins[s] = '0;
        end
    end

    assign user_ready[periph_pkg::SLOT_GPIO] = 1'b1;

    periph_decode periph_decode_i (
        .i_addr        (i_addr),
        .i_read_n      (i_read_n),
        .i_hold_ready  (hold_ready),
        .i_user_data   (user_data),
        .i_user_ready  (user_ready),
        .i_simple_data (simple_data),
        .o_user_sel    (user_sel),
        .o_simple_sel  (simple_sel),
        .o_read_start  (read_start),
        .o_peri_data   (peri_data),
        .o_peri_ready  (peri_ready)
    );

    gpio_ctrl gpio_ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_sel      (user_sel[periph_pkg::SLOT_GPIO]),
        .i_write    (write_req),
        .i_offset   (i_addr[5:0]),
        .i_data     (i_data),
        .i_pins_in  (i_pins_in),
        .o_gpio_out (user_pins[periph_pkg::SLOT_GPIO]),
        .o_func_sel (func_sel),
        .o_rdata    (user_data[periph_pkg::SLOT_GPIO])
    );

    scratch_periph scratch_periph_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_sel        (user_sel[periph_pkg::SLOT_SCRATCH]),
        .i_write_n    (i_write_n),
        .i_read_start (read_start),
        .i_offset     (i_addr[5:0]),
        .i_data       (i_data),
        .o_rdata      (user_data[periph_pkg::SLOT_SCRATCH]),
        .o_ready      (user_ready[periph_pkg::SLOT_SCRATCH]),
        .o_pins       (user_pins[periph_pkg::SLOT_SCRATCH]),
        .o_interrupt  (o_user_interrupt)
    );

    byte_regs_periph #(
        .NUM_REGS (NUM_BYTE_REGS)
    ) byte_regs_periph_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_write  (byte_write),
        .i_offset (i_addr[3:0]),
        .i_data   (i_data[7:0]),
        .o_rdata  (simple_data[periph_pkg::SLOT_BYTE_REGS]),
        .o_pins   (simple_pins[periph_pkg::SLOT_BYTE_REGS])
    );

    read_hold read_hold_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_req      (read_req),
        .i_write_req     (write_req),
        .i_read_complete (i_read_complete),
        .i_peri_data     (peri_data),
        .i_peri_ready    (peri_ready),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready),
        .o_ready_r       (hold_ready)   // Masks the next read
    );

    pin_mux pin_mux_i (
        .i_func_sel    (func_sel),
        .i_user_pins   (user_pins),
        .i_simple_pins (simple_pins),
        .o_pins        (o_pins)
    );

endmodule

`default_nettype wire

// ==== src/pin_mux.sv ====
`default_nettype none
`timescale 1ns/10ps

module pin_mux (
    input  periph_pkg::func_sel_t i_func_sel [8],
    input  periph_pkg::byte_t     i_user_pins [16],
    input  periph_pkg::byte_t     i_simple_pins [16],
    output periph_pkg::byte_t     o_pins
);

    for (genvar n = 0; n < 8; n++) begin : g_pin
        periph_pkg::byte_t src_byte;
        logic              use_simple;
        periph_pkg::slot_t src_slot;

        assign use_simple = i_func_sel[n][4];
        assign src_slot   = i_func_sel[n][3:0];

        // Whole source byte first, then this pin's bit
        assign src_byte = use_simple ? i_simple_pins[src_slot] : i_user_pins[src_slot];
        assign o_pins[n] = src_byte[n];
    end

endmodule

`default_nettype wire

// ==== src/read_hold.sv ====
`default_nettype none
`timescale 1ns/10ps

module read_hold (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_read_req,
    input  logic              i_write_req,
    input  logic              i_read_complete,
    input  periph_pkg::data_t i_peri_data,
    input  logic              i_peri_ready,
    output periph_pkg::data_t o_data,
    output logic              o_data_ready,
    output logic              o_ready_r
);

    logic hold;
    logic capture;

    // First ready cycle of a read while nothing is held
    assign capture = !hold && i_peri_ready && i_read_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold      <= 1'b0;
            o_ready_r <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end
            if (capture) begin
                hold <= 1'b1;
            end
            o_ready_r <= i_read_req && i_peri_ready;  // Lines up with o_data
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            o_data <= i_peri_data;
        end
    end

    // Writes are acknowledged in the same cycle
    assign o_data_ready = o_ready_r || i_write_req;

endmodule

`default_nettype wire

// ==== src/scratch_periph.sv ====
`default_nettype none
`timescale 1ns/10ps

module scratch_periph (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_sel,
    input  periph_pkg::size_n_t i_write_n,
    input  logic                i_read_start,
    input  logic [5:0]          i_offset,
    input  periph_pkg::data_t   i_data,
    output periph_pkg::data_t   o_rdata,
    output logic                o_ready,
    output periph_pkg::byte_t   o_pins,
    output logic                o_interrupt
);

    periph_pkg::data_t scratch;
    logic              wr_en;
    logic              rd_en;

    assign wr_en = i_sel && (i_write_n != periph_pkg::SIZE_IDLE);
    assign rd_en = i_sel && i_read_start;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scratch     <= '0;
            o_interrupt <= 1'b0;
        end else if (wr_en) begin
            if (i_offset == periph_pkg::SCRATCH_DATA_OFS) begin
                case (i_write_n)
                    periph_pkg::SIZE_BYTE: scratch[7:0]  <= i_data[7:0];
                    periph_pkg::SIZE_HALF: scratch[15:0] <= i_data[15:0];
                    periph_pkg::SIZE_WORD: scratch       <= i_data;
                    default: ;
                endcase
                o_interrupt <= 1'b1;  // Any data write raises it
            end else if (i_offset == periph_pkg::SCRATCH_IRQ_OFS) begin
                o_interrupt <= 1'b0;  // Write to clear
            end
        end
    end

    // Read answers one cycle late
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_ready <= 1'b0;
        end else begin
            o_ready <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (i_offset == periph_pkg::SCRATCH_DATA_OFS) begin
                o_rdata <= scratch;
            end else if (i_offset == periph_pkg::SCRATCH_IRQ_OFS) begin
                o_rdata <= {31'h0, o_interrupt};
            end else begin
                o_rdata <= '0;
            end
        end
    end

    assign o_pins = scratch[7:0];

endmodule

`default_nettype wire

// ==== tb/periph_top_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module periph_top_tb;

    localparam int MAX_OPS       = 160;
    localparam int RESET_CYCLES  = 8;
    localparam int READ_WAIT_MAX = 8;
    localparam int BYTE_REGS     = 4;
    localparam logic [1:0] KIND_WRITE = 2'd0;
    localparam logic [1:0] KIND_READ  = 2'd1;
    localparam logic [1:0] KIND_PINS  = 2'd2;

    logic                clk;
    logic                rst_n;
    periph_pkg::byte_t   i_pins_in;
    periph_pkg::byte_t   o_pins;
    periph_pkg::addr_t   i_addr;
    periph_pkg::data_t   i_data;
    periph_pkg::size_n_t i_write_n;
    periph_pkg::size_n_t i_read_n;
    logic                i_read_complete;
    periph_pkg::data_t   o_data;
    logic                o_data_ready;
    logic                o_user_interrupt;

    // Operation table
    logic [1:0]          op_kind [MAX_OPS];
    periph_pkg::addr_t   op_addr [MAX_OPS];
    periph_pkg::size_n_t op_size [MAX_OPS];
    periph_pkg::data_t   op_data [MAX_OPS];
    periph_pkg::data_t   op_exp  [MAX_OPS];
    logic                op_irq  [MAX_OPS];  // Interrupt level before the op
    int                  num_ops = 0;

    // Register map model
    periph_pkg::byte_t     m_gpio_out;
    periph_pkg::func_sel_t m_sel [8];
    periph_pkg::data_t     m_scratch;
    logic                  m_irq;
    periph_pkg::byte_t     m_bregs [BYTE_REGS];

    int error_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    tb_clock tb_clock_i (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    periph_top periph_top_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_pins_in        (i_pins_in),
        .o_pins           (o_pins),
        .i_addr           (i_addr),
        .i_data           (i_data),
        .i_write_n        (i_write_n),
        .i_read_n         (i_read_n),
        .i_read_complete  (i_read_complete),
        .o_data           (o_data),
        .o_data_ready     (o_data_ready),
        .o_user_interrupt (o_user_interrupt)
    );

    task automatic report_error(input string what);
        error_count++;
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycle_limit);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    task automatic wait_after_edge();
        @(posedge clk);
        #1;
    endtask

    function automatic periph_pkg::addr_t user_addr(input periph_pkg::slot_t slot,
                                                    input logic [5:0] ofs);
        return {1'b0, slot, ofs};
    endfunction

    function automatic periph_pkg::addr_t simple_addr(input periph_pkg::slot_t slot,
                                                      input logic [3:0] ofs);
        return {1'b1, 2'b00, slot, ofs};
    endfunction

    task automatic reset_model();
        m_gpio_out = '0;
        m_scratch  = '0;
        m_irq      = 1'b0;
        for (int n = 0; n < 8; n++) m_sel[n] = {1'b0, periph_pkg::SLOT_GPIO};
        for (int r = 0; r < BYTE_REGS; r++) m_bregs[r] = '0;
    endtask

    function automatic periph_pkg::data_t model_read(input periph_pkg::addr_t a);
        logic [5:0]        ofs;
        periph_pkg::data_t rd;
        ofs = a[5:0];
        rd  = '0;  // Empty slots and unused offsets
        if (a[10]) begin
            if (a[7:4] == periph_pkg::SLOT_BYTE_REGS && a[3:0] < BYTE_REGS)
                rd = {24'h0, m_bregs[a[3:0]]};
        end else if (a[9:6] == periph_pkg::SLOT_GPIO) begin
            if (ofs == periph_pkg::GPIO_OUT_OFS) rd = {24'h0, m_gpio_out};
            else if (ofs == periph_pkg::GPIO_IN_OFS) rd = {24'h0, i_pins_in};
            else if (ofs >= periph_pkg::GPIO_SEL_BASE && ofs[1:0] == 2'b00)
                rd = {27'h0, m_sel[ofs[4:2]]};
        end else if (a[9:6] == periph_pkg::SLOT_SCRATCH) begin
            if (ofs == periph_pkg::SCRATCH_DATA_OFS) rd = m_scratch;
            else if (ofs == periph_pkg::SCRATCH_IRQ_OFS) rd = {31'h0, m_irq};
        end
        return rd;
    endfunction

    task automatic model_write(input periph_pkg::addr_t a, input periph_pkg::size_n_t sz,
                               input periph_pkg::data_t d);
        logic [5:0] ofs;
        ofs = a[5:0];
        if (a[10]) begin
            if (a[7:4] == periph_pkg::SLOT_BYTE_REGS && a[3:0] < BYTE_REGS)
                m_bregs[a[3:0]] = d[7:0];
        end else if (a[9:6] == periph_pkg::SLOT_GPIO) begin
            if (ofs == periph_pkg::GPIO_OUT_OFS) m_gpio_out = d[7:0];
            else if (ofs >= periph_pkg::GPIO_SEL_BASE && ofs[1:0] == 2'b00)
                m_sel[ofs[4:2]] = d[4:0];
        end else if (a[9:6] == periph_pkg::SLOT_SCRATCH) begin
            if (ofs == periph_pkg::SCRATCH_DATA_OFS) begin
                case (sz)
                    periph_pkg::SIZE_BYTE: m_scratch[7:0]  = d[7:0];
                    periph_pkg::SIZE_HALF: m_scratch[15:0] = d[15:0];
                    default:               m_scratch       = d;
                endcase
                m_irq = 1'b1;
            end else if (ofs == periph_pkg::SCRATCH_IRQ_OFS) begin
                m_irq = 1'b0;
            end
        end
    endtask

    // Each pin takes its own bit from the selected source byte
    function automatic periph_pkg::byte_t model_pins();
        periph_pkg::byte_t pins;
        periph_pkg::byte_t src;
        pins = '0;
        for (int n = 0; n < 8; n++) begin
            if (m_sel[n][4]) src = (m_sel[n][3:0] == periph_pkg::SLOT_BYTE_REGS) ? m_bregs[0] : '0;
            else if (m_sel[n][3:0] == periph_pkg::SLOT_GPIO) src = m_gpio_out;
            else if (m_sel[n][3:0] == periph_pkg::SLOT_SCRATCH) src = m_scratch[7:0];
            else src = '0;
            pins[n] = src[n];
        end
        return pins;
    endfunction

    function automatic int read_latency(input periph_pkg::addr_t a);
        return (!a[10] && a[9:6] == periph_pkg::SLOT_SCRATCH) ? 2 : 1;
    endfunction

    task automatic add_op(input logic [1:0] kind, input periph_pkg::addr_t a,
                          input periph_pkg::size_n_t sz, input periph_pkg::data_t d,
                          input periph_pkg::data_t exp);
        op_kind[num_ops] = kind;
        op_addr[num_ops] = a;
        op_size[num_ops] = sz;
        op_data[num_ops] = d;
        op_exp[num_ops]  = exp;
        op_irq[num_ops]  = m_irq;
        num_ops++;
    endtask

    task automatic add_write(input periph_pkg::addr_t a, input periph_pkg::size_n_t sz,
                             input periph_pkg::data_t d);
        add_op(KIND_WRITE, a, sz, d, '0);
        model_write(a, sz, d);
    endtask

    task automatic add_read(input periph_pkg::addr_t a);
        add_op(KIND_READ, a, a[10] ? periph_pkg::SIZE_BYTE : periph_pkg::SIZE_WORD, '0,
               model_read(a));
    endtask

    task automatic add_pin_check();
        add_op(KIND_PINS, '0, periph_pkg::SIZE_IDLE, '0, {24'h0, model_pins()});
    endtask

    task automatic build_table();
        periph_pkg::addr_t scr_data;
        periph_pkg::addr_t scr_irq;
        scr_data = user_addr(periph_pkg::SLOT_SCRATCH, periph_pkg::SCRATCH_DATA_OFS);
        scr_irq  = user_addr(periph_pkg::SLOT_SCRATCH, periph_pkg::SCRATCH_IRQ_OFS);
        add_pin_check();  // Reset state
        add_write(user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_OUT_OFS),
                  periph_pkg::SIZE_WORD, $urandom());
        add_pin_check();
        add_read(user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_OUT_OFS));
        add_read(user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_IN_OFS));
        add_read(user_addr(periph_pkg::SLOT_GPIO, 6'h08));
        add_read(user_addr(periph_pkg::SLOT_GPIO, 6'h22));
        add_read(user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_SEL_BASE));
        // Scratch merges and interrupt
        add_write(scr_data, periph_pkg::SIZE_WORD, $urandom());
        add_read(scr_data);
        add_write(scr_data, periph_pkg::SIZE_BYTE, $urandom());
        add_read(scr_data);
        add_write(scr_data, periph_pkg::SIZE_HALF, $urandom());
        add_read(scr_data);
        add_read(scr_irq);
        add_write(scr_irq, periph_pkg::SIZE_WORD, $urandom());
        add_read(scr_irq);
        // Byte register file, offsets past the file read zero
        for (int r = 0; r < BYTE_REGS; r++)
            add_write(simple_addr(periph_pkg::SLOT_BYTE_REGS, 4'(r)), periph_pkg::SIZE_BYTE,
                      $urandom());
        for (int r = 0; r < 16; r++) add_read(simple_addr(periph_pkg::SLOT_BYTE_REGS, 4'(r)));
        // Even pins from scratch, odd pins from the byte registers
        add_write(scr_data, periph_pkg::SIZE_WORD, $urandom());
        for (int n = 0; n < 8; n++)
            add_write(user_addr(periph_pkg::SLOT_GPIO, 6'(periph_pkg::GPIO_SEL_BASE + 4 * n)),
                      periph_pkg::SIZE_WORD, (n % 2 == 0) ?
                      {27'h0, 1'b0, periph_pkg::SLOT_SCRATCH} :
                      {27'h0, 1'b1, periph_pkg::SLOT_BYTE_REGS});
        add_pin_check();
        for (int n = 0; n < 8; n++)
            add_read(user_addr(periph_pkg::SLOT_GPIO, 6'(periph_pkg::GPIO_SEL_BASE + 4 * n)));
        add_write(user_addr(periph_pkg::SLOT_GPIO, 6'h28), periph_pkg::SIZE_WORD, 32'h05);
        add_write(user_addr(periph_pkg::SLOT_GPIO, 6'h34), periph_pkg::SIZE_WORD, 32'h17);
        add_write(user_addr(periph_pkg::SLOT_GPIO, 6'h3C), periph_pkg::SIZE_WORD, $urandom());
        add_pin_check();
        add_write(simple_addr(periph_pkg::SLOT_BYTE_REGS, 4'h0), periph_pkg::SIZE_BYTE,
                  $urandom());
        add_write(scr_data, periph_pkg::SIZE_BYTE, $urandom());
        add_pin_check();
        // Empty slots ignore writes and read zero
        for (int s = 0; s < 16; s++) begin
            if (s != periph_pkg::SLOT_GPIO && s != periph_pkg::SLOT_SCRATCH) begin
                add_write(user_addr(4'(s), 6'h00), periph_pkg::SIZE_WORD, $urandom());
                add_read(user_addr(4'(s), 6'($urandom())));
            end
        end
        for (int s = 1; s < 16; s++) begin
            add_write(simple_addr(4'(s), 4'h0), periph_pkg::SIZE_BYTE, $urandom());
            add_read(simple_addr(4'(s), 4'($urandom())));
        end
        add_pin_check();
        add_read(scr_data);
        add_write(scr_irq, periph_pkg::SIZE_WORD, '0);
        add_pin_check();
    endtask

    task automatic run_op(input int i);
        int waited;
        int delay;
        wait_after_edge();
        assert (o_user_interrupt === op_irq[i])
            else report_error($sformatf("mismatch o_user_interrupt: got 0x%0h expected 0x%0h",
                                        o_user_interrupt, op_irq[i]));
        case (op_kind[i])
            KIND_WRITE: begin
                i_addr    = op_addr[i];
                i_data    = op_data[i];
                i_write_n = op_size[i];
                #1;
                assert (o_data_ready === 1'b1)
                    else report_error($sformatf("mismatch o_data_ready: got 0x%0h expected 0x1",
                                                o_data_ready));
                wait_after_edge();
                i_write_n = periph_pkg::SIZE_IDLE;
            end
            KIND_READ: begin
                i_addr   = op_addr[i];
                i_read_n = op_size[i];
                wait_after_edge();
                waited = 1;
                while (o_data_ready !== 1'b1 && waited < READ_WAIT_MAX) begin
                    wait_after_edge();
                    waited++;
                end
                assert (o_data_ready === 1'b1)
                    else report_error($sformatf("o_data_ready never rose for the read of 0x%03h",
                                                op_addr[i]));
                assert (waited == read_latency(op_addr[i]))
                    else report_error($sformatf("read of 0x%03h answered after %0d cycles",
                                                op_addr[i], waited));
                assert (o_data === op_exp[i])
                    else report_error($sformatf("mismatch o_data: got 0x%08h expected 0x%08h",
                                                o_data, op_exp[i]));
                // Core still drives the read in the ready cycle, pins move meanwhile
                i_pins_in = ~i_pins_in;
                wait_after_edge();
                assert (o_data === op_exp[i])
                    else report_error($sformatf("mismatch o_data held: got 0x%08h exp 0x%08h",
                                                o_data, op_exp[i]));
                i_pins_in = ~i_pins_in;
                i_read_n  = periph_pkg::SIZE_IDLE;
                delay     = $urandom_range(5, 0);  // Core late with read complete
                repeat (delay) begin
                    wait_after_edge();
                    assert (o_data === op_exp[i])
                        else report_error($sformatf("mismatch o_data held: got 0x%08h exp 0x%08h",
                                                    o_data, op_exp[i]));
                end
                i_read_complete = 1'b1;
                wait_after_edge();
                i_read_complete = 1'b0;
            end
            default: begin
                assert (o_pins === op_exp[i][7:0])
                    else report_error($sformatf("mismatch o_pins: got 0x%02h expected 0x%02h",
                                                o_pins, op_exp[i][7:0]));
            end
        endcase
    endtask

    initial begin
        void'($urandom(20713));
        i_addr          = '0;
        i_data          = '0;
        i_write_n       = periph_pkg::SIZE_IDLE;
        i_read_n        = periph_pkg::SIZE_IDLE;
        i_read_complete = 1'b0;
        i_pins_in       = 8'($urandom());
        reset_model();
        build_table();
        cycle_limit = RESET_CYCLES + 40 * num_ops;
        wait (rst_n === 1'b1);
        for (int i = 0; i < num_ops; i++) run_op(i);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_clock (
    output logic o_clk,
    output logic o_rst_n
);

    localparam int RESET_CYCLES = 8;

    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;  // 4 ns period
    end

    // Release lines up with the stimulus drive point
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire
